/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    // ALU and branch functions share one code field
    typedef enum logic [4:0] {
        alu_x     = 5'd0,
        alu_add   = 5'd1,
        alu_sub   = 5'd2,
        alu_and   = 5'd3,
        alu_or    = 5'd4,
        alu_xor   = 5'd5,
        alu_sll   = 5'd6,
        alu_srl   = 5'd7,
        alu_sra   = 5'd8,
        alu_slt   = 5'd9,
        alu_sltu  = 5'd10,
        br_beq    = 5'd11,
        br_bne    = 5'd12,
        br_blt    = 5'd13,
        br_bge    = 5'd14,
        br_bltu   = 5'd15,
        br_bgeu   = 5'd16,
        alu_jalr  = 5'd17,
        alu_copy1 = 5'd18
    } exe_fun_t;

    // idle codes of the control fields
    localparam logic [4:0] men_x = 5'd0;
    localparam logic       ren_x = 1'b0;
    localparam logic [3:0] wb_x  = 4'd0;
    localparam logic [2:0] csr_x = 3'd0;

    localparam logic [xlen-1:0] poison = '1;

    typedef struct packed {
        logic [xlen-1:0] pc;
        exe_fun_t        exe_fun;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        logic [xlen-1:0] rs2_data;
        logic [4:0]      mem_wen;
        logic            rf_wen;
        logic [3:0]      wb_sel;
        logic [4:0]      wb_addr;
        logic [2:0]      csr_cmd;
        logic            jmp_flg;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] imm_b;
        logic            is_ecall;
    } ex_in_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      mem_wen;
        logic            rf_wen;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] op1;
        logic [3:0]      wb_sel;
        logic [4:0]      wb_addr;
        logic [2:0]      csr_cmd;
        logic            jmp_flg;
        logic [xlen-1:0] imm_i;
        logic            is_ecall;
        logic [xlen-1:0] alu_out;
    } ex_out_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

    localparam ex_in_t ex_in_bubble = '{
        pc:       poison,
        exe_fun:  alu_x,
        op1:      poison,
        op2:      poison,
        rs2_data: poison,
        mem_wen:  men_x,
        rf_wen:   ren_x,
        wb_sel:   wb_x,
        wb_addr:  5'd0,
        csr_cmd:  csr_x,
        jmp_flg:  1'b0,
        imm_i:    poison,
        imm_b:    poison,
        is_ecall: 1'b0
    };

    localparam ex_out_t ex_out_bubble = '{
        pc:       poison,
        mem_wen:  men_x,
        rf_wen:   ren_x,
        rs2_data: poison,
        op1:      poison,
        wb_sel:   wb_x,
        wb_addr:  5'd0,
        csr_cmd:  csr_x,
        jmp_flg:  1'b0,
        imm_i:    poison,
        is_ecall: 1'b0,
        alu_out:  poison
    };

    localparam br_t br_bubble = '{taken: 1'b0, target: poison};

endpackage

/* verilog/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  rv_pkg::exe_fun_t        exe_fun,
    input  logic [rv_pkg::xlen-1:0] op1,
    input  logic [rv_pkg::xlen-1:0] op2,
    output logic [rv_pkg::xlen-1:0] result
);

    logic [rv_pkg::xlen-1:0] sum;
    logic [4:0]              shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign sum         = op1 + op2;
    assign shamt       = op2[4:0];
    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        case (exe_fun)
            rv_pkg::alu_add: begin
                result = sum;
            end
            rv_pkg::alu_sub: begin
                result = op1 - op2;
            end
            rv_pkg::alu_and:   result = op1 & op2;
            rv_pkg::alu_or:    result = op1 | op2;
            rv_pkg::alu_xor:   result = op1 ^ op2;
            rv_pkg::alu_sll:   result = op1 << shamt;
            rv_pkg::alu_srl:   result = op1 >> shamt;
            rv_pkg::alu_sra:   result = $unsigned($signed(op1) >>> shamt);
            // compares give 0 or 1
            rv_pkg::alu_slt:   result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
            rv_pkg::alu_sltu:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
            // jump target is halfword aligned
            rv_pkg::alu_jalr: begin
                result = {sum[rv_pkg::xlen-1:1], 1'b0};
            end
            rv_pkg::alu_copy1: result = op1;
            // branch and unknown codes
            default:           result = '0;
        endcase
    end

endmodule

/* verilog/ex_branch.sv */
`timescale 1ns/1ps

module ex_branch (
    input  rv_pkg::exe_fun_t        exe_fun,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] imm_b,
    input  logic [rv_pkg::xlen-1:0] op1,
    input  logic [rv_pkg::xlen-1:0] op2,
    output rv_pkg::br_t             br
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = op1 == op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (exe_fun)
            rv_pkg::br_beq:  br.taken = eq;
            rv_pkg::br_bne:  br.taken = !eq;
            rv_pkg::br_blt:  br.taken = lt_s;
            rv_pkg::br_bge:  br.taken = !lt_s;
            rv_pkg::br_bltu: br.taken = lt_u;
            rv_pkg::br_bgeu: br.taken = !lt_u;
            default:         br.taken = 1'b0;
        endcase
        // target computed even when not a branch
        br.target = pc + imm_b;
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            stall_flg,
    input  rv_pkg::ex_in_t  ex_in,
    output rv_pkg::ex_out_t ex_out,
    output rv_pkg::br_t     br
);

    // replay slot for stalls
    rv_pkg::ex_in_t          saved;
    rv_pkg::ex_in_t          active;
    rv_pkg::ex_out_t         next_out;
    logic [rv_pkg::xlen-1:0] alu_result;
    rv_pkg::br_t             br_result;

    assign active = stall_flg ? saved : ex_in;

    ex_alu u_alu (
        .exe_fun (active.exe_fun),
        .op1     (active.op1),
        .op2     (active.op2),
        .result  (alu_result)
    );

    ex_branch u_branch (
        .exe_fun (active.exe_fun),
        .pc      (active.pc),
        .imm_b   (active.imm_b),
        .op1     (active.op1),
        .op2     (active.op2),
        .br      (br_result)
    );

    // fields carried on to memory and write-back
    always_comb begin
        next_out.pc       = active.pc;
        next_out.mem_wen  = active.mem_wen;
        next_out.rf_wen   = active.rf_wen;
        next_out.rs2_data = active.rs2_data;
        next_out.op1      = active.op1;
        next_out.wb_sel   = active.wb_sel;
        next_out.wb_addr  = active.wb_addr;
        next_out.csr_cmd  = active.csr_cmd;
        next_out.jmp_flg  = active.jmp_flg;
        next_out.imm_i    = active.imm_i;
        next_out.is_ecall = active.is_ecall;
        next_out.alu_out  = alu_result;
    end

    // flush beats stall, and also empties the replay slot
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            saved  <= rv_pkg::ex_in_bubble;
            ex_out <= rv_pkg::ex_out_bubble;
            br     <= rv_pkg::br_bubble;
        end else begin
            saved  <= active;
            ex_out <= next_out;
            br     <= br_result;
        end
    end

endmodule

/* verilog/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            stall_flg,
    input  rv_pkg::ex_in_t  ex_in,
    output rv_pkg::ex_out_t ex_out,
    output rv_pkg::br_t     br
);

    // flush is the branch hazard from write-back
    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .stall_flg (stall_flg),
        .ex_in     (ex_in),
        .ex_out    (ex_out),
        .br        (br)
    );

endmodule

/* testbench/ex_assertions.sv */
`timescale 1ns/1ps

module ex_assertions (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input rv_pkg::exe_fun_t  active_fun,
    input rv_pkg::ex_out_t   ex_out,
    input rv_pkg::br_t       br
);

    logic is_branch;
    int   fail_count = 0;

    assign is_branch = active_fun inside {rv_pkg::br_beq, rv_pkg::br_bne, rv_pkg::br_blt,
                                          rv_pkg::br_bge, rv_pkg::br_bltu, rv_pkg::br_bgeu};

    flush_clears: assert property (@(posedge clk) flush |=> (!ex_out.rf_wen && !br.taken))
        else begin
            $error("rf_wen or br.taken still set after a flush");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk) rst |=> (ex_out.mem_wen == rv_pkg::men_x))
        else begin
            $error("mem_wen not idle after reset");
            fail_count++;
        end

    // only branch codes may take a branch
    no_stray_taken: assert property (@(posedge clk) disable iff (rst) !is_branch |=> !br.taken)
        else begin
            $error("branch taken for a non-branch function code");
            fail_count++;
        end

endmodule

bind execute_stage ex_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .active_fun (active.exe_fun),
    .ex_out     (ex_out),
    .br         (br)
);

/* testbench/tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;

    localparam int reset_cycles = 5;
    localparam int total_cycles = 2000;

    logic            clk;
    logic            rst;
    logic            flush;
    logic            stall_flg;
    rv_pkg::ex_in_t  ex_in;
    rv_pkg::ex_out_t ex_out;
    rv_pkg::br_t     br;

    integer seed = 32'h4fa8;
    int     errors = 0;
    int     checks = 0;
    int     assert_fails;
    int     cycle;

    // reference model state
    rv_pkg::ex_in_t  model_saved;
    rv_pkg::ex_out_t exp_out;
    rv_pkg::br_t     exp_br;
    string           exp_tag;

    ex_top uut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .stall_flg (stall_flg),
        .ex_in     (ex_in),
        .ex_out    (ex_out),
        .br        (br)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] alu_model(rv_pkg::exe_fun_t f, logic [31:0] a,
                                              logic [31:0] b);
        logic [63:0] ext;
        logic [4:0]  sh;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (f)
            rv_pkg::alu_add:   return a + b;
            rv_pkg::alu_sub:   return a + ~b + 32'd1;
            rv_pkg::alu_and:   return a & b;
            rv_pkg::alu_or:    return a | b;
            rv_pkg::alu_xor:   return a ^ b;
            rv_pkg::alu_sll:   return a << sh;
            rv_pkg::alu_srl:   return a >> sh;
            rv_pkg::alu_sra:   return ext[31:0];
            // signed compare as offset binary
            rv_pkg::alu_slt:   return ({~a[31], a[30:0]} < {~b[31], b[30:0]}) ? 32'd1 : 32'd0;
            rv_pkg::alu_sltu:  return (a < b) ? 32'd1 : 32'd0;
            rv_pkg::alu_jalr:  return (a + b) & 32'hffff_fffe;
            rv_pkg::alu_copy1: return a;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic taken_model(rv_pkg::exe_fun_t f, logic [31:0] a, logic [31:0] b);
        logic lt_s;
        lt_s = {~a[31], a[30:0]} < {~b[31], b[30:0]};
        case (f)
            rv_pkg::br_beq:  return a == b;
            rv_pkg::br_bne:  return a != b;
            rv_pkg::br_blt:  return lt_s;
            rv_pkg::br_bge:  return !lt_s;
            rv_pkg::br_bltu: return a < b;
            rv_pkg::br_bgeu: return !(a < b);
            default:         return 1'b0;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        check_word({exp_tag, " alu_out"}, exp_out.alu_out, ex_out.alu_out);
        check_word({exp_tag, " br.taken"}, 32'(exp_br.taken), 32'(br.taken));
        check_word({exp_tag, " br.target"}, exp_br.target, br.target);
        check_word({exp_tag, " pc"}, exp_out.pc, ex_out.pc);
        check_word({exp_tag, " rs2_data"}, exp_out.rs2_data, ex_out.rs2_data);
        check_word({exp_tag, " op1"}, exp_out.op1, ex_out.op1);
        check_word({exp_tag, " imm_i"}, exp_out.imm_i, ex_out.imm_i);
        check_word({exp_tag, " mem_wen"}, 32'(exp_out.mem_wen), 32'(ex_out.mem_wen));
        check_word({exp_tag, " rf_wen"}, 32'(exp_out.rf_wen), 32'(ex_out.rf_wen));
        check_word({exp_tag, " wb_sel"}, 32'(exp_out.wb_sel), 32'(ex_out.wb_sel));
        check_word({exp_tag, " wb_addr"}, 32'(exp_out.wb_addr), 32'(ex_out.wb_addr));
        check_word({exp_tag, " csr_cmd"}, 32'(exp_out.csr_cmd), 32'(ex_out.csr_cmd));
        check_word({exp_tag, " jmp_flg"}, 32'(exp_out.jmp_flg), 32'(ex_out.jmp_flg));
        check_word({exp_tag, " is_ecall"}, 32'(exp_out.is_ecall), 32'(ex_out.is_ecall));
    endtask

    // equal pairs and sign boundaries now and then
    task automatic pick_operands(output logic [31:0] a, output logic [31:0] b);
        logic [31:0] r;
        r = $random(seed);
        a = $random(seed);
        b = $random(seed);
        if (r % 5 == 0) begin
            case (r[10:8])
                3'd0: b = a;
                3'd1: {a, b} = {32'h8000_0000, 32'h7fff_ffff};
                3'd2: {a, b} = {32'h7fff_ffff, 32'h8000_0000};
                3'd3: {a, b} = {32'h0000_0000, 32'hffff_ffff};
                3'd4: {a, b} = {32'hffff_ffff, 32'h0000_0000};
                3'd5: {a, b} = {32'h8000_0000, 32'h8000_0000};
                3'd6: b = a + 32'd1;
                default: {a, b} = 64'd0;
            endcase
        end
    endtask

    task automatic drive_inputs(input int n);
        logic [31:0]    r;
        logic [31:0]    a;
        logic [31:0]    b;
        rv_pkg::ex_in_t in;
        rst = (n + 1 < reset_cycles);
        r = $random(seed);
        stall_flg = (r % 10) < 2;
        r = $random(seed);
        flush = (r % 10) == 0;
        // codes 19 and 20 are not valid
        r = $unsigned($random(seed)) % 21;
        in.exe_fun = rv_pkg::exe_fun_t'(r[4:0]);
        pick_operands(a, b);
        in.op1      = a;
        in.op2      = b;
        in.pc       = $random(seed);
        in.rs2_data = $random(seed);
        in.imm_i    = $random(seed);
        in.imm_b    = $random(seed);
        r = $random(seed);
        in.mem_wen  = r[4:0];
        in.rf_wen   = r[5];
        in.wb_sel   = r[9:6];
        in.wb_addr  = r[14:10];
        in.csr_cmd  = r[17:15];
        in.jmp_flg  = r[18];
        in.is_ecall = r[19];
        ex_in = in;
    endtask

    task automatic predict_outputs();
        rv_pkg::ex_in_t act;
        act = stall_flg ? model_saved : ex_in;
        if (rst) exp_tag = "reset";
        else if (flush) exp_tag = "flush";
        else if (stall_flg) exp_tag = "stall replay";
        else exp_tag = "execute";
        if (rst || flush) begin
            exp_out     = rv_pkg::ex_out_bubble;
            exp_br      = rv_pkg::br_bubble;
            model_saved = rv_pkg::ex_in_bubble;
        end else begin
            exp_out.pc       = act.pc;
            exp_out.mem_wen  = act.mem_wen;
            exp_out.rf_wen   = act.rf_wen;
            exp_out.rs2_data = act.rs2_data;
            exp_out.op1      = act.op1;
            exp_out.wb_sel   = act.wb_sel;
            exp_out.wb_addr  = act.wb_addr;
            exp_out.csr_cmd  = act.csr_cmd;
            exp_out.jmp_flg  = act.jmp_flg;
            exp_out.imm_i    = act.imm_i;
            exp_out.is_ecall = act.is_ecall;
            exp_out.alu_out  = alu_model(act.exe_fun, act.op1, act.op2);
            exp_br.taken     = taken_model(act.exe_fun, act.op1, act.op2);
            exp_br.target    = act.pc + act.imm_b;
            model_saved      = act;
        end
    endtask

    initial begin
        rst         = 1'b1;
        flush       = 1'b0;
        stall_flg   = 1'b0;
        ex_in       = rv_pkg::ex_in_bubble;
        model_saved = rv_pkg::ex_in_bubble;
        predict_outputs();
        // check, drive, then predict the next edge
        for (cycle = 0; cycle < total_cycles; cycle++) begin
            @(negedge clk);
            compare_outputs();
            drive_inputs(cycle);
            predict_outputs();
        end
        assert_fails = uut.u_execute.u_assertions.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/rv_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/execute_stage.sv
verilog/ex_top.sv
testbench/ex_assertions.sv
testbench/tb_ex_top.sv
